//--- rtl/raster_pkg.sv
// Coordinate width and fraction bits are fixed here; box extents should be multiples of the step
`default_nettype none

package raster_pkg;

    // Signed fixed-point coordinate width
    localparam int SIGFIG = 24;
    // Fraction bits, one pixel is 1 << RADIX
    localparam int RADIX = 10;

    // Triangle geometry
    localparam int VERTS = 3;
    // x, y and z per vertex
    localparam int AXES = 3;

    // Colour channels
    localparam int COLORS = 3;

    // Integer part in [SIGFIG-1:RADIX], fraction in [RADIX-1:0]
    typedef logic signed [SIGFIG-1:0] fixed_t;

    // Sample location
    typedef struct packed {
        fixed_t x;
        fixed_t y;
    } point_t;

    // Bounding box corners
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    // One vertex, index 0 is x
    typedef fixed_t [AXES-1:0] vertex_t;

    // Full triangle
    typedef vertex_t [VERTS-1:0] tri_t;

    // Unsigned colour channel
    typedef logic [SIGFIG-1:0] channel_t;

    typedef channel_t [COLORS-1:0] color_t;

    // Payload carried alongside every sample of a box
    typedef struct packed {
        tri_t   geom;
        color_t color;
    } prim_t;

    // Iterator state
    typedef enum logic {
        ITER_WAIT = 1'b0,
        ITER_TEST = 1'b1
    } iter_state_e;

    // Subsample code, one-hot
    // Shifted left by RADIX-3 it gives the step in fixed point
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000,
        MSAA_4X  = 4'b0100,
        MSAA_16X = 4'b0010,
        MSAA_64X = 4'b0001
    } msaa_e;

endpackage

`default_nettype wire

//--- rtl/sample_stepper.sv
// Purely combinational; codes outside msaa_e step by one pixel, msaa must be static during a scan
`timescale 1ns/100ps
`default_nettype none

module sample_stepper
    import raster_pkg::*;
(
    // Current registered sample
    input  point_t sample,
    // Box being scanned
    input  box_t   cur_box,
    // Subsample code
    input  msaa_e  msaa,

    // Next sample on the same row
    output point_t right_pt,
    // First sample on the next row
    output point_t up_pt,

    // Edge flags for the current sample
    output logic   at_right,
    output logic   at_top,
    output logic   at_end
);

    // Sanitized one-hot code
    logic [3:0] code;

    // Step size in fixed point
    fixed_t step;

    // Illegal codes fall back to a single sample per pixel
    always_comb begin
        case (msaa)
            MSAA_1X,
            MSAA_4X,
            MSAA_16X,
            MSAA_64X: begin
                code = msaa;
            end
            default: begin
                code = MSAA_1X;
            end
        endcase
    end

    // 4'b1000 << 7 is 1024, one pixel
    assign step = fixed_t'(code) << (RADIX - 3);

    // Right candidate keeps the row
    always_comb begin
        right_pt.x = sample.x + step;
        right_pt.y = sample.y;
    end

    // Up candidate restarts at the left edge
    always_comb begin
        up_pt.x = cur_box.ll.x;
        up_pt.y = sample.y + step;
    end

    // Signed compares against the upper-right corner
    // Using >= keeps the scan finite when extents are not step multiples
    always_comb begin
        at_right = (sample.x >= cur_box.ur.x);
        at_top   = (sample.y >= cur_box.ur.y);
    end

    // Last sample of the box
    assign at_end = at_right && at_top;

endmodule

`default_nettype wire

//--- rtl/sample_iter_fsm.sv
// Upstream must hold box, payload and tri_valid while halt is high; no downstream back-pressure
`timescale 1ns/100ps
`default_nettype none

module sample_iter_fsm
    import raster_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // Upstream box and payload
    input  prim_t  prim_in,
    input  box_t   box_in,
    input  logic   tri_valid,

    // Candidates and flags from the stepper
    input  point_t right_pt,
    input  point_t up_pt,
    input  logic   at_right,
    input  logic   at_end,

    // Registered box for the stepper
    output box_t   cur_box,

    // Downstream sample stream
    output point_t sample,
    output prim_t  prim_out,
    output logic   sample_valid,

    // Holds upstream during a scan
    output logic   halt
);

    iter_state_e state;
    iter_state_e state_next;

    point_t sample_next;
    prim_t  prim_next;
    logic   valid_next;
    logic   halt_next;

    // New box taken this cycle
    logic   accept;

    assign accept = (state == ITER_WAIT) && tri_valid;

    // Next-state and next-output logic
    always_comb begin
        // Hold by default
        state_next  = state;
        sample_next = sample;
        prim_next   = prim_out;
        valid_next  = sample_valid;
        halt_next   = halt;

        case (state)
            ITER_WAIT: begin
                if (tri_valid) begin
                    // First sample is the lower-left corner
                    state_next  = ITER_TEST;
                    sample_next = box_in.ll;
                    prim_next   = prim_in;
                    valid_next  = 1'b1;
                    halt_next   = 1'b1;
                end else begin
                    valid_next  = 1'b0;
                    halt_next   = 1'b0;
                end
            end

            ITER_TEST: begin
                if (at_end) begin
                    // Release upstream after the last sample
                    state_next  = ITER_WAIT;
                    sample_next = cur_box.ll;
                    valid_next  = 1'b0;
                    halt_next   = 1'b0;
                end else if (at_right) begin
                    // Wrap to the next row
                    sample_next = up_pt;
                end else begin
                    sample_next = right_pt;
                end
            end

            default: begin
                state_next = ITER_WAIT;
                valid_next = 1'b0;
                halt_next  = 1'b0;
            end
        endcase
    end

    // Control and output registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ITER_WAIT;
            sample       <= '0;
            prim_out     <= '0;
            sample_valid <= 1'b0;
            halt         <= 1'b0;
        end else begin
            state        <= state_next;
            sample       <= sample_next;
            prim_out     <= prim_next;
            sample_valid <= valid_next;
            halt         <= halt_next;
        end
    end

    // Box register, loaded once per scan
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_box <= box_in;
        end
    end

    // Accepted box starts a scan at its lower-left corner
    a_wait_to_test: assert property (
        @(posedge clk) disable iff (rst)
        (state == ITER_WAIT) && tri_valid |=>
            (state == ITER_TEST) && sample_valid && (sample == $past(box_in.ll))
    ) else $error("wait to test transition failed");

    // Idle stays idle without a box
    a_wait_stay: assert property (
        @(posedge clk) disable iff (rst)
        (state == ITER_WAIT) && !tri_valid |=> (state == ITER_WAIT) && !sample_valid
    ) else $error("wait state left without tri_valid");

    // End of box returns to idle
    a_test_to_wait: assert property (
        @(posedge clk) disable iff (rst)
        (state == ITER_TEST) && at_end |=> (state == ITER_WAIT) && !sample_valid
    ) else $error("test to wait transition failed");

    // Scan continues until the end flag
    a_test_stay: assert property (
        @(posedge clk) disable iff (rst)
        (state == ITER_TEST) && !at_end |=> (state == ITER_TEST) && sample_valid
    ) else $error("scan ended early");

    // Every issued sample lies inside the box
    a_in_box: assert property (
        @(posedge clk) disable iff (rst)
        sample_valid |->
            (sample.x >= cur_box.ll.x) && (sample.x <= cur_box.ur.x) &&
            (sample.y >= cur_box.ll.y) && (sample.y <= cur_box.ur.y)
    ) else $error("sample outside bounding box");

    // Halt tracks valid and the scan state
    a_halt_valid: assert property (
        @(posedge clk) disable iff (rst)
        (halt == sample_valid) && (sample_valid == (state == ITER_TEST))
    ) else $error("halt and sample_valid disagree");

    // Payload is frozen for the whole scan
    a_prim_stable: assert property (
        @(posedge clk) disable iff (rst)
        sample_valid && $past(sample_valid) |-> $stable(prim_out)
    ) else $error("payload changed during scan");

endmodule

`default_nettype wire

//--- rtl/raster_sample_iter.sv
// One-cycle latency from acceptance to first sample; box extents should be multiples of the step
`timescale 1ns/100ps
`default_nettype none

module raster_sample_iter
    import raster_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // From the bounding-box stage
    input  prim_t  prim_in,
    input  box_t   box_in,
    input  logic   tri_valid,

    // Static during a scan
    input  msaa_e  msaa,

    // Back to the bounding-box stage
    output logic   halt,

    // To the sample test stage
    output prim_t  prim_out,
    output point_t sample,
    output logic   sample_valid
);

    // Box held by the FSM
    box_t   cur_box;

    // Stepper results
    point_t right_pt;
    point_t up_pt;
    logic   at_right;
    logic   at_end;

    // Registered state and outputs
    sample_iter_fsm i_fsm (
        .clk          (clk),
        .rst          (rst),
        .prim_in      (prim_in),
        .box_in       (box_in),
        .tri_valid    (tri_valid),
        .right_pt     (right_pt),
        .up_pt        (up_pt),
        .at_right     (at_right),
        .at_end       (at_end),
        .cur_box      (cur_box),
        .sample       (sample),
        .prim_out     (prim_out),
        .sample_valid (sample_valid),
        .halt         (halt)
    );

    // Next-sample candidates from the registered sample
    // Top-edge flag alone is folded into at_end and not needed here
    sample_stepper i_stepper (
        .sample   (sample),
        .cur_box  (cur_box),
        .msaa     (msaa),
        .right_pt (right_pt),
        .up_pt    (up_pt),
        .at_right (at_right),
        .at_top   (),
        .at_end   (at_end)
    );

endmodule

`default_nettype wire

//--- test/raster_sample_iter_tb.sv
// Directed tests only; box extents are kept to multiples of the step and the run stops at 2000 cycles
`timescale 1ns/100ps
`default_nettype none

module raster_sample_iter_tb
    import raster_pkg::*;
;

    // 20 ns clock, 4 reset cycles
    localparam int RESET_CYCLES = 4;
    // Run limit in clock cycles
    localparam int MAX_CYCLES = 2000;
    // Longest wait for the first sample of a box
    localparam int START_LIMIT = 4;

    logic   clk;
    logic   rst;
    prim_t  prim_in;
    box_t   box_in;
    logic   tri_valid;
    msaa_e  msaa;
    logic   halt;
    prim_t  prim_out;
    point_t sample;
    logic   sample_valid;

    // Reference sample list for the box under test
    point_t exp_q[$];

    int seed = 84;
    int cycles = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    raster_sample_iter i_dut (
        .clk          (clk),
        .rst          (rst),
        .prim_in      (prim_in),
        .box_in       (box_in),
        .tri_valid    (tri_valid),
        .msaa         (msaa),
        .halt         (halt),
        .prim_out     (prim_out),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Hard stop if a test never returns
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_bit(input string name, input string what, input logic exp_v,
                             input logic act_v);
        assert (act_v === exp_v) else begin
            $display("Fail %s: %s expected %0b actual %0b", name, what, exp_v, act_v);
            count_error();
        end
    endtask

    task automatic check_point(input string name, input int idx, input point_t exp_p,
                               input point_t act_p);
        assert (act_p === exp_p) else begin
            $display("Fail %s: sample %0d expected (%0d,%0d) actual (%0d,%0d)",
                     name, idx, exp_p.x, exp_p.y, act_p.x, act_p.y);
            count_error();
        end
    endtask

    task automatic check_prim(input string name, input prim_t exp_p, input prim_t act_p);
        assert (act_p === exp_p) else begin
            $display("Fail %s: prim_out expected %h actual %h", name, exp_p, act_p);
            count_error();
        end
    endtask

    // 288 bits of payload from nine 32-bit draws
    task automatic random_prim(output prim_t p);
        logic [$bits(prim_t)-1:0] bits;
        for (int k = 0; k < $bits(prim_t) / 32; k++) begin
            bits[k*32 +: 32] = $random(seed);
        end
        p = bits;
    endtask

    function automatic box_t make_box(input int llx, input int lly, input int urx,
                                      input int ury);
        box_t b;
        b.ll.x = fixed_t'(llx);
        b.ll.y = fixed_t'(lly);
        b.ur.x = fixed_t'(urx);
        b.ur.y = fixed_t'(ury);
        return b;
    endfunction

    // Left to right, bottom to top, last sample at or beyond the upper-right corner
    task automatic build_expected(input box_t b, input logic [3:0] code);
        int step;
        int x;
        int y;
        bit row_done;
        bit box_done;
        point_t pt;
        exp_q.delete();
        // Half, quarter or eighth pixel, anything else one pixel
        case (code)
            4'b0100: step = (1 << RADIX) / 2;
            4'b0010: step = (1 << RADIX) / 4;
            4'b0001: step = (1 << RADIX) / 8;
            default: step = 1 << RADIX;
        endcase
        y = b.ll.y;
        box_done = 1'b0;
        while (!box_done) begin
            x = b.ll.x;
            row_done = 1'b0;
            while (!row_done) begin
                pt.x = fixed_t'(x);
                pt.y = fixed_t'(y);
                exp_q.push_back(pt);
                if (x >= b.ur.x) row_done = 1'b1;
                else x += step;
            end
            if (y >= b.ur.y) box_done = 1'b1;
            else y += step;
        end
    endtask

    // Upstream presents a box on the rising edge
    task automatic apply_box(input box_t b, input prim_t p, input logic [3:0] code);
        @(posedge clk);
        box_in    <= b;
        prim_in   <= p;
        msaa      <= msaa_e'(code);
        tri_valid <= 1'b1;
    endtask

    // Follows one scan from the drive edge; optionally chains the next box at the last sample
    task automatic check_scan(input string name, input prim_t p_exp, input bit scramble,
                              input bit chain, input box_t nb, input prim_t np);
        int low;
        prim_t junk;
        low = 0;
        @(negedge clk);
        while (!sample_valid && low < START_LIMIT) begin
            check_bit(name, "halt before scan", 1'b0, halt);
            low++;
            @(negedge clk);
        end
        assert (sample_valid) else begin
            $display("Error %s: sample_valid never rose after the box was presented", name);
            count_error();
        end
        if (sample_valid) begin
            // One idle cycle, then the first sample
            assert (low == 1) else begin
                $display("Fail %s: idle cycles before scan expected 1 actual %0d", name, low);
                count_error();
            end
            for (int i = 0; i < exp_q.size(); i++) begin
                if (i > 0) begin
                    // Payload input changes mid-scan and prim_out must not follow
                    if (scramble && i == 2) begin
                        @(posedge clk);
                        random_prim(junk);
                        prim_in <= junk;
                    end
                    @(negedge clk);
                end
                check_bit(name, "sample_valid", 1'b1, sample_valid);
                check_bit(name, "halt", 1'b1, halt);
                check_point(name, i, exp_q[i], sample);
                check_prim(name, p_exp, prim_out);
            end
            // Halt falls at this edge and upstream moves on
            @(posedge clk);
            if (chain) begin
                box_in    <= nb;
                prim_in   <= np;
                tri_valid <= 1'b1;
            end else begin
                tri_valid <= 1'b0;
            end
            if (!chain) begin
                @(negedge clk);
                check_bit(name, "sample_valid after scan", 1'b0, sample_valid);
                check_bit(name, "halt after scan", 1'b0, halt);
            end
        end
    endtask

    task automatic begin_test();
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic test_reset();
        begin_test();
        @(negedge clk);
        check_bit("reset", "sample_valid", 1'b0, sample_valid);
        check_bit("reset", "halt", 1'b0, halt);
        check_point("reset", 0, '0, sample);
        check_prim("reset", '0, prim_out);
        end_test("reset");
    endtask

    // Single box with a fresh payload
    task automatic test_scan(input string name, input box_t b, input logic [3:0] code,
                             input int exp_count);
        prim_t p;
        begin_test();
        random_prim(p);
        build_expected(b, code);
        assert (exp_q.size() == exp_count) else begin
            $display("Fail %s: reference count expected %0d actual %0d",
                     name, exp_count, exp_q.size());
            count_error();
        end
        apply_box(b, p, code);
        check_scan(name, p, 1'b0, 1'b0, '0, '0);
        end_test(name);
    endtask

    // Second box offered as the first one finishes, negative coordinates included
    task automatic test_back_to_back();
        prim_t p1;
        prim_t p2;
        box_t  b1;
        box_t  b2;
        begin_test();
        random_prim(p1);
        random_prim(p2);
        b1 = make_box(5 * 1024, 3 * 1024, 8 * 1024, 5 * 1024);
        b2 = make_box(-2048, -1024, -1024, 0);
        build_expected(b1, MSAA_4X);
        apply_box(b1, p1, MSAA_4X);
        check_scan("back_to_back", p1, 1'b1, 1'b1, b2, p2);
        build_expected(b2, MSAA_4X);
        check_scan("back_to_back", p2, 1'b0, 1'b0, '0, '0);
        end_test("back_to_back");
    endtask

    initial begin
        rst       = 1'b1;
        prim_in   = '0;
        box_in    = '0;
        tri_valid = 1'b0;
        msaa      = MSAA_1X;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        // 3 by 2 pixel box
        test_scan("msaa_1x", make_box(5 * 1024, 3 * 1024, 8 * 1024, 5 * 1024), MSAA_1X, 12);
        test_scan("msaa_4x", make_box(5 * 1024, 3 * 1024, 8 * 1024, 5 * 1024), MSAA_4X, 35);
        test_scan("msaa_16x", make_box(5 * 1024, 3 * 1024, 8 * 1024, 5 * 1024), MSAA_16X, 117);
        test_scan("degenerate", make_box(10 * 1024, 7 * 1024, 10 * 1024, 7 * 1024), MSAA_1X, 1);
        test_back_to_back();
        // Code outside msaa_e steps by one pixel
        test_scan("illegal_msaa", make_box(5 * 1024, 3 * 1024, 8 * 1024, 5 * 1024), 4'b0011, 12);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/raster_pkg.sv
rtl/sample_stepper.sv
rtl/sample_iter_fsm.sv
rtl/raster_sample_iter.sv
test/raster_sample_iter_tb.sv

//--- Bender.yml
package:
  name: raster_sample_iter

dependencies: {}

sources:
  - rtl/raster_pkg.sv
  - rtl/sample_stepper.sv
  - rtl/sample_iter_fsm.sv
  - rtl/raster_sample_iter.sv
  - target: test
    files:
      - test/raster_sample_iter_tb.sv
